/* roc_cfg.svh */
/*
 * Build-time sizes for the read-only cache.
 * Include wherever the address, word or cache geometry is needed.
 */

`ifndef ROC_CFG_SVH
`define ROC_CFG_SVH

// Address and data widths in bits
`define ROC_ADDR_W 32
`define ROC_WORD_W 32

// Cache geometry, both powers of two
`define ROC_LINE_WORDS 4
`define ROC_LINE_COUNT 16

// Number of cacheable region rules
`define ROC_NR_RULES 2

`endif

/* roc_cache_pkg.sv */
/*
 * Data and address types of the read-only cache.
 * Field positions inside a byte address are derived here from the cfg macros.
 */

`include "roc_cfg.svh"

package roc_cache_pkg;

  // Address split: | tag | index | offset | byte |
  localparam int unsigned BYTE_W    = $clog2(`ROC_WORD_W / 8);
  localparam int unsigned OFFSET_W  = $clog2(`ROC_LINE_WORDS);
  localparam int unsigned INDEX_W   = $clog2(`ROC_LINE_COUNT);
  localparam int unsigned INDEX_LSB = BYTE_W + OFFSET_W;
  localparam int unsigned TAG_W     = `ROC_ADDR_W - INDEX_LSB - INDEX_W;

  typedef logic [`ROC_ADDR_W-1:0] addr_t;
  typedef logic [`ROC_WORD_W-1:0] word_t;
  typedef word_t [`ROC_LINE_WORDS-1:0] line_t;

  typedef logic [INDEX_W-1:0]  index_t;
  typedef logic [OFFSET_W-1:0] offset_t;
  typedef logic [TAG_W-1:0]    tag_t;

  // Beats minus one of a memory read
  typedef logic [OFFSET_W-1:0] len_t;

endpackage

/* roc_ctrl_pkg.sv */
/*
 * Control encodings of the read-only cache.
 * Holds the request route and the refill state machine states.
 */

`include "roc_cfg.svh"

package roc_ctrl_pkg;

  // Path taken by one read
  typedef enum logic {
    ROUTE_BYPASS = 1'b0,
    ROUTE_CACHE  = 1'b1
  } route_e;

  // Result stage states
  typedef enum logic [2:0] {
    IDLE,
    HIT_RSP,
    MEM_REQ,
    MEM_DATA,
    RSP
  } refill_state_e;

endpackage

/* roc_route_decode.sv */
/*
 * Chooses cache or bypass for each read request.
 * The route is combinational and held while a request waits for ready.
 */

`timescale 1ns/10ps

`include "roc_cfg.svh"

module roc_route_decode (
  input  logic                                     clk_i,
  input  logic                                     rst_n_i,
  input  logic                                     enable_i,
  input  logic                                     req_valid_i,
  input  logic                                     req_ready_i,
  input  roc_cache_pkg::addr_t                     req_addr_i,
  input  logic                                     req_lock_i,
  input  roc_cache_pkg::addr_t [`ROC_NR_RULES-1:0] start_addr_i,
  input  roc_cache_pkg::addr_t [`ROC_NR_RULES-1:0] end_addr_i,
  output roc_ctrl_pkg::route_e                     route_o
);

  logic                 in_region;
  logic                 waiting_q;
  roc_ctrl_pkg::route_e route_d;
  roc_ctrl_pkg::route_e route_q;

  // Start inclusive, end exclusive
  always_comb begin
    in_region = 1'b0;
    for (int i = 0; i < `ROC_NR_RULES; i++) begin
      if (req_addr_i >= start_addr_i[i] && req_addr_i < end_addr_i[i]) begin
        in_region = 1'b1;
      end
    end
  end

  // Locked reads and a disabled cache always bypass
  always_comb begin
    route_d = roc_ctrl_pkg::ROUTE_BYPASS;
    if (in_region && enable_i && !req_lock_i) begin
      route_d = roc_ctrl_pkg::ROUTE_CACHE;
    end
  end

  assign route_o = waiting_q ? route_q : route_d;

  // Remember the route of a request that is not yet accepted
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      route_q   <= roc_ctrl_pkg::ROUTE_BYPASS;
      waiting_q <= 1'b0;
    end else begin
      route_q   <= route_o;
      waiting_q <= req_valid_i && !req_ready_i;
    end
  end

endmodule

/* roc_tag_lookup.sv */
/*
 * Direct-mapped tag, valid and data store of the read-only cache.
 * Accepts one request at a time, reports hit or miss one cycle later,
 * serves flushes while idle and takes refilled lines from the result stage.
 */

`timescale 1ns/10ps

`include "roc_cfg.svh"

module roc_tag_lookup (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    req_valid_i,
  output logic                    req_ready_o,
  input  roc_cache_pkg::addr_t    req_addr_i,
  input  roc_ctrl_pkg::route_e    route_i,
  input  logic                    flush_valid_i,
  output logic                    flush_ready_o,
  input  logic                    done_i,
  input  logic                    wr_valid_i,
  input  roc_cache_pkg::index_t   wr_index_i,
  input  roc_cache_pkg::tag_t     wr_tag_i,
  input  roc_cache_pkg::line_t    wr_line_i,
  output logic                    lk_valid_o,
  output logic                    lk_hit_o,
  output roc_cache_pkg::word_t    lk_word_o,
  output roc_cache_pkg::addr_t    lk_addr_o,
  output roc_ctrl_pkg::route_e    lk_route_o
);

  logic                       busy_q;
  logic                       lk_valid_q;
  logic                       accept;
  logic [`ROC_LINE_COUNT-1:0] valid_q;
  roc_cache_pkg::tag_t        tag_q  [`ROC_LINE_COUNT];
  roc_cache_pkg::line_t       data_q [`ROC_LINE_COUNT];
  roc_cache_pkg::addr_t       addr_q;
  roc_ctrl_pkg::route_e       route_q;
  roc_cache_pkg::index_t      lk_index;
  roc_cache_pkg::offset_t     lk_offset;
  roc_cache_pkg::tag_t        lk_tag;

  // A pending flush holds off new requests
  assign req_ready_o   = !busy_q && !flush_valid_i;
  assign flush_ready_o = flush_valid_i && !busy_q;
  assign accept        = req_valid_i && req_ready_o;

  // --------------------------------------------------
  // Hit check on the registered address
  // --------------------------------------------------
  assign lk_index  = addr_q[roc_cache_pkg::INDEX_LSB +: roc_cache_pkg::INDEX_W];
  assign lk_offset = addr_q[roc_cache_pkg::BYTE_W +: roc_cache_pkg::OFFSET_W];
  assign lk_tag    = addr_q[`ROC_ADDR_W-1 -: roc_cache_pkg::TAG_W];

  assign lk_valid_o = lk_valid_q;
  assign lk_hit_o   = lk_valid_q && (route_q == roc_ctrl_pkg::ROUTE_CACHE) &&
                      valid_q[lk_index] && (tag_q[lk_index] == lk_tag);
  assign lk_word_o  = data_q[lk_index][lk_offset];
  assign lk_addr_o  = addr_q;
  assign lk_route_o = route_q;

  // --------------------------------------------------
  // Control state and valid bits
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q     <= 1'b0;
      lk_valid_q <= 1'b0;
      valid_q    <= '0;
    end else begin
      lk_valid_q <= accept;
      // Busy until the response of this request is taken
      if (accept) begin
        busy_q <= 1'b1;
      end else if (done_i) begin
        busy_q <= 1'b0;
      end
      if (flush_ready_o) begin
        valid_q <= '0;
      end else if (wr_valid_i) begin
        valid_q[wr_index_i] <= 1'b1;
      end
    end
  end

  // Request capture and line storage
  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_q  <= req_addr_i;
      route_q <= route_i;
    end
    if (wr_valid_i) begin
      tag_q[wr_index_i]  <= wr_tag_i;
      data_q[wr_index_i] <= wr_line_i;
    end
  end

endmodule

/* roc_refill_ctrl.sv */
/*
 * Result stage of the read-only cache.
 * Answers hits from the lookup word, fetches lines on a miss and single
 * words on a bypass, then returns exactly one response per request.
 */

`timescale 1ns/10ps

`include "roc_cfg.svh"

module roc_refill_ctrl (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   lk_valid_i,
  input  logic                   lk_hit_i,
  input  roc_cache_pkg::word_t   lk_word_i,
  input  roc_cache_pkg::addr_t   lk_addr_i,
  input  roc_ctrl_pkg::route_e   lk_route_i,
  output logic                   rsp_valid_o,
  input  logic                   rsp_ready_i,
  output roc_cache_pkg::word_t   rsp_data_o,
  output logic                   rsp_error_o,
  output logic                   mem_req_valid_o,
  input  logic                   mem_req_ready_i,
  output roc_cache_pkg::addr_t   mem_req_addr_o,
  output roc_cache_pkg::len_t    mem_req_len_o,
  input  logic                   mem_rsp_valid_i,
  input  roc_cache_pkg::word_t   mem_rsp_data_i,
  input  logic                   mem_rsp_error_i,
  input  logic                   mem_rsp_last_i,
  output logic                   wr_valid_o,
  output roc_cache_pkg::index_t  wr_index_o,
  output roc_cache_pkg::tag_t    wr_tag_o,
  output roc_cache_pkg::line_t   wr_line_o,
  output logic                   done_o,
  output logic                   ev_hit_o,
  output logic                   ev_miss_o,
  output logic                   ev_bypass_o
);

  roc_ctrl_pkg::refill_state_e state_q;
  roc_ctrl_pkg::refill_state_e state_d;
  roc_cache_pkg::offset_t      cnt_q;
  logic                        err_q;
  logic                        wr_valid_q;
  logic                        beat_take;
  roc_cache_pkg::word_t        rsp_data_q;
  roc_cache_pkg::line_t        line_q;
  roc_cache_pkg::addr_t        addr_q;
  roc_ctrl_pkg::route_e        route_q;
  roc_cache_pkg::addr_t        mem_addr_q;
  roc_cache_pkg::len_t         mem_len_q;

  assign beat_take = (state_q == roc_ctrl_pkg::MEM_DATA) && mem_rsp_valid_i;

  // --------------------------------------------------
  // State machine
  // --------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      roc_ctrl_pkg::IDLE: begin
        if (lk_valid_i) begin
          state_d = lk_hit_i ? roc_ctrl_pkg::HIT_RSP : roc_ctrl_pkg::MEM_REQ;
        end
      end
      roc_ctrl_pkg::MEM_REQ: begin
        if (mem_req_ready_i) begin
          state_d = roc_ctrl_pkg::MEM_DATA;
        end
      end
      roc_ctrl_pkg::MEM_DATA: begin
        if (beat_take && mem_rsp_last_i) begin
          state_d = roc_ctrl_pkg::RSP;
        end
      end
      roc_ctrl_pkg::HIT_RSP, roc_ctrl_pkg::RSP: begin
        if (rsp_ready_i) begin
          state_d = roc_ctrl_pkg::IDLE;
        end
      end
      default: state_d = roc_ctrl_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q    <= roc_ctrl_pkg::IDLE;
      cnt_q      <= '0;
      err_q      <= 1'b0;
      wr_valid_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      // Only an error-free cache refill updates the store
      wr_valid_q <= beat_take && mem_rsp_last_i && (route_q == roc_ctrl_pkg::ROUTE_CACHE) &&
                    !(err_q || mem_rsp_error_i);
      if (lk_valid_i) begin
        cnt_q <= '0;
        err_q <= 1'b0;
      end else if (beat_take) begin
        cnt_q <= cnt_q + 1'b1;
        err_q <= err_q | mem_rsp_error_i;
      end
    end
  end

  // --------------------------------------------------
  // Request capture and beat collection
  // --------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (lk_valid_i) begin
      addr_q     <= lk_addr_i;
      route_q    <= lk_route_i;
      rsp_data_q <= lk_word_i;
      if (lk_route_i == roc_ctrl_pkg::ROUTE_CACHE) begin
        // Whole line from its first word
        mem_addr_q <= {lk_addr_i[`ROC_ADDR_W-1:roc_cache_pkg::INDEX_LSB],
                       {roc_cache_pkg::INDEX_LSB{1'b0}}};
        mem_len_q  <= roc_cache_pkg::len_t'(`ROC_LINE_WORDS - 1);
      end else begin
        mem_addr_q <= {lk_addr_i[`ROC_ADDR_W-1:roc_cache_pkg::BYTE_W],
                       {roc_cache_pkg::BYTE_W{1'b0}}};
        mem_len_q  <= '0;
      end
    end
    if (beat_take) begin
      line_q[cnt_q] <= mem_rsp_data_i;
      // Keep the beat the requester asked for
      if ((route_q == roc_ctrl_pkg::ROUTE_BYPASS) ||
          (cnt_q == addr_q[roc_cache_pkg::BYTE_W +: roc_cache_pkg::OFFSET_W])) begin
        rsp_data_q <= mem_rsp_data_i;
      end
    end
  end

  // --------------------------------------------------
  // Outputs
  // --------------------------------------------------
  assign rsp_valid_o = (state_q == roc_ctrl_pkg::HIT_RSP) || (state_q == roc_ctrl_pkg::RSP);
  assign rsp_data_o  = rsp_data_q;
  // Cleared on the lookup strobe, so a hit never reports an error
  assign rsp_error_o = err_q;
  assign done_o      = rsp_valid_o && rsp_ready_i;

  assign mem_req_valid_o = (state_q == roc_ctrl_pkg::MEM_REQ);
  assign mem_req_addr_o  = mem_addr_q;
  assign mem_req_len_o   = mem_len_q;

  assign wr_valid_o = wr_valid_q;
  assign wr_index_o = addr_q[roc_cache_pkg::INDEX_LSB +: roc_cache_pkg::INDEX_W];
  assign wr_tag_o   = addr_q[`ROC_ADDR_W-1 -: roc_cache_pkg::TAG_W];
  assign wr_line_o  = line_q;

  assign ev_hit_o    = lk_valid_i && lk_hit_i;
  assign ev_miss_o   = lk_valid_i && !lk_hit_i && (lk_route_i == roc_ctrl_pkg::ROUTE_CACHE);
  assign ev_bypass_o = lk_valid_i && (lk_route_i == roc_ctrl_pkg::ROUTE_BYPASS);

endmodule

/* roc_top.sv */
/*
 * Read-only cache between one requester and one memory.
 * Connects route decode, tag lookup and the refill result stage.
 */

`timescale 1ns/10ps

`include "roc_cfg.svh"

module roc_top (
  input  logic                                     clk_i,
  input  logic                                     rst_n_i,
  input  logic                                     enable_i,
  input  roc_cache_pkg::addr_t [`ROC_NR_RULES-1:0] start_addr_i,
  input  roc_cache_pkg::addr_t [`ROC_NR_RULES-1:0] end_addr_i,
  input  logic                                     flush_valid_i,
  output logic                                     flush_ready_o,
  input  logic                                     req_valid_i,
  output logic                                     req_ready_o,
  input  roc_cache_pkg::addr_t                     req_addr_i,
  input  logic                                     req_lock_i,
  output logic                                     rsp_valid_o,
  input  logic                                     rsp_ready_i,
  output roc_cache_pkg::word_t                     rsp_data_o,
  output logic                                     rsp_error_o,
  output logic                                     mem_req_valid_o,
  input  logic                                     mem_req_ready_i,
  output roc_cache_pkg::addr_t                     mem_req_addr_o,
  output roc_cache_pkg::len_t                      mem_req_len_o,
  input  logic                                     mem_rsp_valid_i,
  input  roc_cache_pkg::word_t                     mem_rsp_data_i,
  input  logic                                     mem_rsp_error_i,
  input  logic                                     mem_rsp_last_i,
  output logic                                     ev_hit_o,
  output logic                                     ev_miss_o,
  output logic                                     ev_bypass_o
);

  roc_ctrl_pkg::route_e  route;
  logic                  lk_valid;
  logic                  lk_hit;
  roc_cache_pkg::word_t  lk_word;
  roc_cache_pkg::addr_t  lk_addr;
  roc_ctrl_pkg::route_e  lk_route;
  logic                  wr_valid;
  roc_cache_pkg::index_t wr_index;
  roc_cache_pkg::tag_t   wr_tag;
  roc_cache_pkg::line_t  wr_line;
  logic                  done;

  roc_route_decode i_route_decode (
    .clk_i        ( clk_i        ),
    .rst_n_i      ( rst_n_i      ),
    .enable_i     ( enable_i     ),
    .req_valid_i  ( req_valid_i  ),
    .req_ready_i  ( req_ready_o  ),
    .req_addr_i   ( req_addr_i   ),
    .req_lock_i   ( req_lock_i   ),
    .start_addr_i ( start_addr_i ),
    .end_addr_i   ( end_addr_i   ),
    .route_o      ( route        )
  );

  roc_tag_lookup i_tag_lookup (
    .clk_i         ( clk_i         ),
    .rst_n_i       ( rst_n_i       ),
    .req_valid_i   ( req_valid_i   ),
    .req_ready_o   ( req_ready_o   ),
    .req_addr_i    ( req_addr_i    ),
    .route_i       ( route         ),
    .flush_valid_i ( flush_valid_i ),
    .flush_ready_o ( flush_ready_o ),
    .done_i        ( done          ),
    .wr_valid_i    ( wr_valid      ),
    .wr_index_i    ( wr_index      ),
    .wr_tag_i      ( wr_tag        ),
    .wr_line_i     ( wr_line       ),
    .lk_valid_o    ( lk_valid      ),
    .lk_hit_o      ( lk_hit        ),
    .lk_word_o     ( lk_word       ),
    .lk_addr_o     ( lk_addr       ),
    .lk_route_o    ( lk_route      )
  );

  roc_refill_ctrl i_refill_ctrl (
    .clk_i           ( clk_i           ),
    .rst_n_i         ( rst_n_i         ),
    .lk_valid_i      ( lk_valid        ),
    .lk_hit_i        ( lk_hit          ),
    .lk_word_i       ( lk_word         ),
    .lk_addr_i       ( lk_addr         ),
    .lk_route_i      ( lk_route        ),
    .rsp_valid_o     ( rsp_valid_o     ),
    .rsp_ready_i     ( rsp_ready_i     ),
    .rsp_data_o      ( rsp_data_o      ),
    .rsp_error_o     ( rsp_error_o     ),
    .mem_req_valid_o ( mem_req_valid_o ),
    .mem_req_ready_i ( mem_req_ready_i ),
    .mem_req_addr_o  ( mem_req_addr_o  ),
    .mem_req_len_o   ( mem_req_len_o   ),
    .mem_rsp_valid_i ( mem_rsp_valid_i ),
    .mem_rsp_data_i  ( mem_rsp_data_i  ),
    .mem_rsp_error_i ( mem_rsp_error_i ),
    .mem_rsp_last_i  ( mem_rsp_last_i  ),
    .wr_valid_o      ( wr_valid        ),
    .wr_index_o      ( wr_index        ),
    .wr_tag_o        ( wr_tag          ),
    .wr_line_o       ( wr_line         ),
    .done_o          ( done            ),
    .ev_hit_o        ( ev_hit_o        ),
    .ev_miss_o       ( ev_miss_o       ),
    .ev_bypass_o     ( ev_bypass_o     )
  );

endmodule

/* tb_roc_top.sv */
/*
 * Directed testbench for the read-only cache top level.
 * Runs a memory model with random accept delay, issues reads through
 * each route and checks data, events, memory requests and handshakes.
 */

`timescale 1ns/10ps

`include "roc_cfg.svh"

module tb_roc_top;

  localparam int TIMEOUT_CYCLES = 2000;
  localparam int KIND_HIT       = 0;
  localparam int KIND_MISS      = 1;
  localparam int KIND_BYPASS    = 2;

  logic                                     clk_i;
  logic                                     rst_n_i;
  logic                                     enable_i;
  roc_cache_pkg::addr_t [`ROC_NR_RULES-1:0] start_addr_i;
  roc_cache_pkg::addr_t [`ROC_NR_RULES-1:0] end_addr_i;
  logic                                     flush_valid_i;
  logic                                     flush_ready_o;
  logic                                     req_valid_i;
  logic                                     req_ready_o;
  roc_cache_pkg::addr_t                     req_addr_i;
  logic                                     req_lock_i;
  logic                                     rsp_valid_o;
  logic                                     rsp_ready_i;
  roc_cache_pkg::word_t                     rsp_data_o;
  logic                                     rsp_error_o;
  logic                                     mem_req_valid_o;
  logic                                     mem_req_ready_i;
  roc_cache_pkg::addr_t                     mem_req_addr_o;
  roc_cache_pkg::len_t                      mem_req_len_o;
  logic                                     mem_rsp_valid_i;
  roc_cache_pkg::word_t                     mem_rsp_data_i;
  logic                                     mem_rsp_error_i;
  logic                                     mem_rsp_last_i;
  logic                                     ev_hit_o;
  logic                                     ev_miss_o;
  logic                                     ev_bypass_o;

  integer               seed = 32'hff2ba90c;
  int                   checks = 0;
  int                   errors = 0;
  int                   cycles = 0;
  int                   mem_count = 0;
  roc_cache_pkg::addr_t last_mem_addr;
  roc_cache_pkg::len_t  last_mem_len;
  int                   ev_hits = 0;
  int                   ev_misses = 0;
  int                   ev_bypasses = 0;

  roc_top dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  // Event pulses last one cycle, so one sample per cycle counts each once
  always @(negedge clk_i) begin
    if (ev_hit_o) ev_hits <= ev_hits + 1;
    if (ev_miss_o) ev_misses <= ev_misses + 1;
    if (ev_bypass_o) ev_bypasses <= ev_bypasses + 1;
  end

  // --------------------------------------------------
  // Memory model
  // --------------------------------------------------
  initial begin : memory_model
    int                   delay;
    roc_cache_pkg::addr_t base;
    roc_cache_pkg::addr_t beat_addr;
    roc_cache_pkg::len_t  len;
    mem_req_ready_i = 1'b0;
    mem_rsp_valid_i = 1'b0;
    mem_rsp_data_i  = '0;
    mem_rsp_error_i = 1'b0;
    mem_rsp_last_i  = 1'b0;
    forever begin
      @(negedge clk_i);
      if (mem_req_valid_o) begin
        base  = mem_req_addr_o;
        len   = mem_req_len_o;
        delay = $unsigned($random(seed)) % 4;
        repeat (delay) @(negedge clk_i);
        check_bit("mem_req_valid_o", mem_req_valid_o, 1'b1);
        compare_word("mem_req_addr_o", mem_req_addr_o, base);
        mem_req_ready_i = 1'b1;
        @(negedge clk_i);
        mem_req_ready_i = 1'b0;
        mem_count++;
        last_mem_addr = base;
        last_mem_len  = len;
        for (int i = 0; i <= int'(len); i++) begin
          beat_addr       = base + 4 * i;
          mem_rsp_valid_i = 1'b1;
          mem_rsp_data_i  = beat_addr ^ 32'h5a5a_0000;
          mem_rsp_error_i = (beat_addr >= 32'h3000) && (beat_addr <= 32'h30ff);
          mem_rsp_last_i  = (i == int'(len));
          @(negedge clk_i);
        end
        mem_rsp_valid_i = 1'b0;
        mem_rsp_error_i = 1'b0;
        mem_rsp_last_i  = 1'b0;
      end
    end
  end

  // --------------------------------------------------
  // Checks and read sequences
  // --------------------------------------------------
  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic compare_word(input string name, input roc_cache_pkg::word_t got,
                              input roc_cache_pkg::word_t exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // Response held for hold cycles of low rsp_ready_i before it is taken
  task automatic read_word(input roc_cache_pkg::addr_t addr, input logic lock,
                           input int hold, output roc_cache_pkg::word_t data,
                           output logic err, output int lat);
    @(negedge clk_i);
    rsp_ready_i = (hold == 0);
    req_valid_i = 1'b1;
    req_addr_i  = addr;
    req_lock_i  = lock;
    while (!req_ready_o) @(negedge clk_i);
    @(negedge clk_i);
    req_valid_i = 1'b0;
    req_lock_i  = 1'b0;
    lat = 1;
    check_bit("req_ready_o", req_ready_o, 1'b0);
    while (!rsp_valid_o) begin
      @(negedge clk_i);
      lat++;
    end
    data = rsp_data_o;
    err  = rsp_error_o;
    repeat (hold) begin
      @(negedge clk_i);
      check_bit("rsp_valid_o", rsp_valid_o, 1'b1);
      compare_word("rsp_data_o", rsp_data_o, data);
      check_bit("rsp_error_o", rsp_error_o, err);
      check_bit("req_ready_o", req_ready_o, 1'b0);
    end
    rsp_ready_i = 1'b1;
    @(negedge clk_i);
    check_bit("rsp_valid_o", rsp_valid_o, 1'b0);
    check_bit("req_ready_o", req_ready_o, 1'b1);
  endtask

  task automatic verify_read(input roc_cache_pkg::addr_t addr, input logic lock,
                             input int kind, input logic exp_err, input int hold);
    int                   mem_before;
    int                   hit_before;
    int                   miss_before;
    int                   byp_before;
    int                   lat;
    roc_cache_pkg::word_t data;
    logic                 err;
    roc_cache_pkg::addr_t word_addr;
    word_addr   = addr & 32'hffff_fffc;
    mem_before  = mem_count;
    hit_before  = ev_hits;
    miss_before = ev_misses;
    byp_before  = ev_bypasses;
    read_word(addr, lock, hold, data, err, lat);
    check_bit("rsp_error_o", err, exp_err);
    if (!exp_err) begin
      compare_word("rsp_data_o", data, word_addr ^ 32'h5a5a_0000);
    end
    compare_word("ev_hit_o count", 32'(ev_hits - hit_before), (kind == KIND_HIT) ? 1 : 0);
    compare_word("ev_miss_o count", 32'(ev_misses - miss_before), (kind == KIND_MISS) ? 1 : 0);
    compare_word("ev_bypass_o count", 32'(ev_bypasses - byp_before),
                 (kind == KIND_BYPASS) ? 1 : 0);
    if (kind == KIND_HIT) begin
      compare_word("mem_req_valid_o count", 32'(mem_count - mem_before), 32'd0);
      compare_word("rsp_valid_o latency", 32'(lat), 32'd2);
    end else begin
      compare_word("mem_req_valid_o count", 32'(mem_count - mem_before), 32'd1);
      // Misses fetch the whole line, bypasses one word
      if (kind == KIND_MISS) begin
        compare_word("mem_req_addr_o", last_mem_addr, addr & 32'hffff_fff0);
        compare_word("mem_req_len_o", 32'(last_mem_len), 32'd3);
      end else begin
        compare_word("mem_req_addr_o", last_mem_addr, word_addr);
        compare_word("mem_req_len_o", 32'(last_mem_len), 32'd0);
      end
    end
  endtask

  // --------------------------------------------------
  // Directed tests
  // --------------------------------------------------
  task automatic bypass_when_disabled();
    enable_i = 1'b0;
    verify_read(32'h0000_1100, 1'b0, KIND_BYPASS, 1'b0, 0);
  endtask

  task automatic miss_then_hits();
    enable_i = 1'b1;
    verify_read(32'h0000_1100, 1'b0, KIND_MISS, 1'b0, 0);
    verify_read(32'h0000_1104, 1'b0, KIND_HIT, 1'b0, 0);
    verify_read(32'h0000_1108, 1'b0, KIND_HIT, 1'b0, 0);
    verify_read(32'h0000_110c, 1'b0, KIND_HIT, 1'b0, 0);
  endtask

  task automatic bypass_rules();
    verify_read(32'h0000_2000, 1'b0, KIND_BYPASS, 1'b0, 0);
    verify_read(32'h0000_8000, 1'b0, KIND_BYPASS, 1'b0, 0);
    verify_read(32'h0000_1104, 1'b1, KIND_BYPASS, 1'b0, 0);
    verify_read(32'h0000_1000, 1'b0, KIND_MISS, 1'b0, 0);
    verify_read(32'h0000_1004, 1'b0, KIND_HIT, 1'b0, 0);
  endtask

  task automatic flush_refetch();
    verify_read(32'h0000_1004, 1'b0, KIND_HIT, 1'b0, 0);
    @(negedge clk_i);
    flush_valid_i = 1'b1;
    while (!flush_ready_o) @(negedge clk_i);
    @(negedge clk_i);
    flush_valid_i = 1'b0;
    verify_read(32'h0000_1004, 1'b0, KIND_MISS, 1'b0, 0);
  endtask

  task automatic rsp_backpressure();
    int hold;
    hold = 1 + $unsigned($random(seed)) % 10;
    verify_read(32'h0000_1008, 1'b0, KIND_HIT, 1'b0, hold);
    hold = 1 + $unsigned($random(seed)) % 10;
    verify_read(32'h0000_1500, 1'b0, KIND_MISS, 1'b0, hold);
  endtask

  // A failed refill leaves the line invalid
  task automatic refill_error();
    verify_read(32'h0000_3040, 1'b0, KIND_MISS, 1'b1, 0);
    verify_read(32'h0000_3044, 1'b0, KIND_MISS, 1'b1, 0);
  endtask

  initial begin
    rst_n_i         = 1'b0;
    enable_i        = 1'b0;
    start_addr_i[0] = 32'h0000_1000;
    end_addr_i[0]   = 32'h0000_2000;
    start_addr_i[1] = 32'h0000_3000;
    end_addr_i[1]   = 32'h0000_4000;
    flush_valid_i   = 1'b0;
    req_valid_i     = 1'b0;
    req_addr_i      = '0;
    req_lock_i      = 1'b0;
    rsp_ready_i     = 1'b1;
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    @(negedge clk_i);
    check_bit("req_ready_o", req_ready_o, 1'b1);
    check_bit("rsp_valid_o", rsp_valid_o, 1'b0);
    check_bit("mem_req_valid_o", mem_req_valid_o, 1'b0);
    check_bit("flush_ready_o", flush_ready_o, 1'b0);

    bypass_when_disabled();
    miss_then_hits();
    bypass_rules();
    flush_refetch();
    rsp_backpressure();
    refill_error();

    repeat (2) @(negedge clk_i);
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

/* sources.f */
+incdir+.
roc_cache_pkg.sv
roc_ctrl_pkg.sv
roc_route_decode.sv
roc_tag_lookup.sv
roc_refill_ctrl.sv
roc_top.sv
tb_roc_top.sv

/* Makefile */
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log for a pass"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f sources.f --top-module tb_roc_top -o sim_tb
	./obj_dir/sim_tb > sim.log 2>&1; cat sim.log
	grep -q "NO ERRORS" sim.log

clean:
	rm -rf obj_dir sim.log
